//--- Makefile
# Verilator flow for the taint-tracking multiplier

VERILATOR ?= verilator
TOP       ?= taint_mul_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)

# Exit status of the simulation binary is the pass/fail result
sim: build
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/mul_controller.sv
// ======================================
// Shift-add multiplier sequencer
// Load, then add/skip and shift per bit
// ======================================
module mul_controller (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         nonempty,
    output logic         pop,
    output logic         result_valid,
    mul_step_if.ctrl     step
);

    taint_mul_pkg::ctrl_state_e state;
    taint_mul_pkg::ctrl_state_e state_next;

    logic [taint_mul_pkg::STEP_CNT_WIDTH-1:0] step_cnt;

    // ======================================
    // State register and step counter
    // ======================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= taint_mul_pkg::ST_IDLE;
            step_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == taint_mul_pkg::ST_LOAD) begin
                step_cnt <= '0;
            end else if (state == taint_mul_pkg::ST_SHIFT) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            taint_mul_pkg::ST_IDLE: begin
                if (nonempty) begin
                    state_next = taint_mul_pkg::ST_LOAD;
                end
            end
            taint_mul_pkg::ST_LOAD: begin
                state_next = taint_mul_pkg::ST_DECIDE;
            end
            taint_mul_pkg::ST_DECIDE: begin
                state_next = taint_mul_pkg::ST_SHIFT;
            end
            taint_mul_pkg::ST_SHIFT: begin
                // Last bit done, go present the product
                if (step_cnt == taint_mul_pkg::STEP_LAST) begin
                    state_next = taint_mul_pkg::ST_DONE;
                end else begin
                    state_next = taint_mul_pkg::ST_DECIDE;
                end
            end
            taint_mul_pkg::ST_DONE: begin
                // Back to back when another pair is waiting
                state_next = nonempty ? taint_mul_pkg::ST_LOAD : taint_mul_pkg::ST_IDLE;
            end
            default: begin
                state_next = taint_mul_pkg::ST_IDLE;
            end
        endcase
    end

    // ======================================
    // Step commands to the datapath
    // ======================================
    always_comb begin
        step.op   = taint_mul_pkg::STEP_IDLE;
        step.op_t = 1'b0;
        case (state)
            taint_mul_pkg::ST_LOAD:  step.op = taint_mul_pkg::STEP_LOAD;
            taint_mul_pkg::ST_DECIDE: begin
                step.op   = step.mr_lsb ? taint_mul_pkg::STEP_ADD : taint_mul_pkg::STEP_SKIP;
                // Decision taint follows the multiplier bit
                step.op_t = step.mr_lsb_t;
            end
            taint_mul_pkg::ST_SHIFT: step.op = taint_mul_pkg::STEP_SHIFT;
            default:                 step.op = taint_mul_pkg::STEP_IDLE;
        endcase
    end

    assign pop          = (state == taint_mul_pkg::ST_LOAD);
    assign result_valid = (state == taint_mul_pkg::ST_DONE);

    // Exactly OP_WIDTH add/shift rounds per multiply
    a_step_bound: assert property (@(posedge clk) disable iff (!rst_n)
        step_cnt <= taint_mul_pkg::STEP_MAX)
        else $error("step counter ran past operand width");

endmodule

//--- hdl/mul_datapath.sv
// ======================================
// Shift-add datapath with taint shadows
// ======================================
module mul_datapath (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  taint_mul_pkg::operand_t                head,
    mul_step_if.dp                                 step,
    output logic [taint_mul_pkg::PROD_WIDTH-1:0]   product,
    output logic [taint_mul_pkg::PROD_WIDTH-1:0]   product_t
);

    // Operand registers and their taint
    logic [taint_mul_pkg::OP_WIDTH-1:0] md;
    logic [taint_mul_pkg::OP_WIDTH-1:0] md_t;
    logic [taint_mul_pkg::OP_WIDTH-1:0] mr;
    logic [taint_mul_pkg::OP_WIDTH-1:0] mr_t;

    // Running sum, top bit holds the add carry until the shift
    logic [taint_mul_pkg::SUM_WIDTH-1:0] sum;
    logic [taint_mul_pkg::SUM_WIDTH-1:0] sum_t;

    // Adder side
    logic [taint_mul_pkg::SUM_WIDTH-1:0] md_ext;
    logic [taint_mul_pkg::SUM_WIDTH-1:0] md_t_ext;
    logic [taint_mul_pkg::SUM_WIDTH-1:0] carry;
    logic [taint_mul_pkg::SUM_WIDTH-1:0] carry_t;
    logic [taint_mul_pkg::SUM_WIDTH-1:0] add_sum;
    logic [taint_mul_pkg::SUM_WIDTH-1:0] add_sum_t;

    // Multiplicand sits in the upper half of the product
    assign md_ext   = {1'b0, md, {taint_mul_pkg::OP_WIDTH{1'b0}}};
    assign md_t_ext = {1'b0, md_t, {taint_mul_pkg::OP_WIDTH{1'b0}}};

    // ======================================
    // Ripple adder with carry taint
    // ======================================
    always_comb begin
        carry      = '0;
        carry_t    = '0;
        for (int k = 0; k < taint_mul_pkg::SUM_WIDTH - 1; k++) begin
            carry[k+1] = (sum[k] & md_ext[k]) | (sum[k] & carry[k]) |
                         (md_ext[k] & carry[k]);
            // Carry out is tainted only if one of the two addend bits is
            carry_t[k+1] = carry[k+1] & (sum_t[k] | md_t_ext[k]);
        end
        add_sum   = sum ^ md_ext ^ carry;
        add_sum_t = sum_t | md_t_ext | carry_t;
    end

    // ======================================
    // Running sum
    // ======================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum   <= '0;
            sum_t <= '0;
        end else begin
            case (step.op)
                taint_mul_pkg::STEP_LOAD: begin
                    sum   <= '0;
                    sum_t <= '0;
                end
                taint_mul_pkg::STEP_ADD: begin
                    sum   <= add_sum;
                    sum_t <= step.op_t ? '1 : add_sum_t;
                end
                taint_mul_pkg::STEP_SKIP: begin
                    // A tainted skip leaks just as much as a tainted add
                    if (step.op_t) begin
                        sum_t <= '1;
                    end
                end
                taint_mul_pkg::STEP_SHIFT: begin
                    sum   <= sum >> 1;
                    sum_t <= sum_t >> 1;
                end
                default: begin
                    sum   <= sum;
                    sum_t <= sum_t;
                end
            endcase
        end
    end

    // Operand registers
    always_ff @(posedge clk) begin
        case (step.op)
            taint_mul_pkg::STEP_LOAD: begin
                md   <= head.multiplicand;
                md_t <= head.multiplicand_t;
                mr   <= head.multiplier;
                mr_t <= head.multiplier_t;
            end
            taint_mul_pkg::STEP_SHIFT: begin
                mr   <= mr >> 1;
                mr_t <= mr_t >> 1;
            end
            default: begin
                mr   <= mr;
                mr_t <= mr_t;
            end
        endcase
    end

    assign step.mr_lsb   = mr[0];
    assign step.mr_lsb_t = mr_t[0];

    assign product   = sum[taint_mul_pkg::PROD_WIDTH-1:0];
    assign product_t = sum_t[taint_mul_pkg::PROD_WIDTH-1:0];

endmodule

//--- hdl/mul_step_if.sv
// ======================================
// Controller to datapath step link
// ======================================
interface mul_step_if;

    // Step command and whether the choice behind it was tainted
    taint_mul_pkg::step_op_e op;
    logic                    op_t;

    // Low multiplier bit fed back for the add/skip choice
    logic mr_lsb;
    logic mr_lsb_t;

    modport ctrl (
        output op,
        output op_t,
        input  mr_lsb,
        input  mr_lsb_t
    );

    modport dp (
        input  op,
        input  op_t,
        output mr_lsb,
        output mr_lsb_t
    );

endinterface

//--- hdl/operand_queue.sv
// ======================================
// Operand FIFO fed by sender credits
// Returns a credit on every pop
// ======================================
module operand_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  taint_mul_pkg::operand_t push_data,
    input  logic                    pop,
    output taint_mul_pkg::operand_t head,
    output logic                    nonempty,
    output logic                    credit_return
);

    taint_mul_pkg::operand_t mem [taint_mul_pkg::OPQ_DEPTH];

    logic [taint_mul_pkg::QPTR_WIDTH-1:0] wr_ptr;
    logic [taint_mul_pkg::QPTR_WIDTH-1:0] rd_ptr;
    logic [taint_mul_pkg::QCNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == taint_mul_pkg::QPTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == taint_mul_pkg::QPTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head     = mem[rd_ptr];
    assign nonempty = (count != '0);

    // One credit back per pair taken out
    assign credit_return = pop;

    // Sender must never spend a credit it does not hold
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && count == taint_mul_pkg::QCNT_FULL))
        else $error("operand queue overflow");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && count == '0))
        else $error("operand queue underflow");

endmodule

//--- hdl/taint_mul_pkg.sv
// ======================================
// Taint multiplier shared definitions
// Widths, queue depth, enums, operand pair
// ======================================
package taint_mul_pkg;

    // Operand and product widths
    localparam int OP_WIDTH   = 8;
    localparam int PROD_WIDTH = 2 * OP_WIDTH;
    // Running sum keeps one extra carry bit
    localparam int SUM_WIDTH  = PROD_WIDTH + 1;

    // Operand queue, also the sender's starting credit count
    localparam int OPQ_DEPTH  = 2;
    localparam int QPTR_WIDTH = $clog2(OPQ_DEPTH);
    localparam int QCNT_WIDTH = QPTR_WIDTH + 1;
    localparam logic [QPTR_WIDTH-1:0] QPTR_LAST = QPTR_WIDTH'(OPQ_DEPTH - 1);
    localparam logic [QCNT_WIDTH-1:0] QCNT_FULL = QCNT_WIDTH'(OPQ_DEPTH);

    // Step counter for the add/shift loop
    localparam int STEP_CNT_WIDTH = $clog2(OP_WIDTH + 1);
    localparam logic [STEP_CNT_WIDTH-1:0] STEP_LAST = STEP_CNT_WIDTH'(OP_WIDTH - 1);
    localparam logic [STEP_CNT_WIDTH-1:0] STEP_MAX  = STEP_CNT_WIDTH'(OP_WIDTH);

    typedef enum logic [2:0] {
        STEP_IDLE,
        STEP_LOAD,
        STEP_ADD,
        STEP_SKIP,
        STEP_SHIFT
    } step_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DECIDE,
        ST_SHIFT,
        ST_DONE
    } ctrl_state_e;

    typedef struct packed {
        logic [OP_WIDTH-1:0] multiplier;
        logic [OP_WIDTH-1:0] multiplier_t;
        logic [OP_WIDTH-1:0] multiplicand;
        logic [OP_WIDTH-1:0] multiplicand_t;
    } operand_t;

endpackage

//--- hdl/taint_mul_top.sv
// ======================================
// Taint-tracking sequential multiplier
// ======================================
module taint_mul_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [taint_mul_pkg::OP_WIDTH-1:0]    multiplier,
    input  logic [taint_mul_pkg::OP_WIDTH-1:0]    multiplier_t,
    input  logic [taint_mul_pkg::OP_WIDTH-1:0]    multiplicand,
    input  logic [taint_mul_pkg::OP_WIDTH-1:0]    multiplicand_t,
    output logic                                  credit_return,
    output logic                                  result_valid,
    output logic [taint_mul_pkg::PROD_WIDTH-1:0]  product,
    output logic [taint_mul_pkg::PROD_WIDTH-1:0]  product_t
);

    taint_mul_pkg::operand_t in_pair;
    taint_mul_pkg::operand_t head;
    logic                    nonempty;
    logic                    pop;

    mul_step_if step_if ();

    // Pack the operand pair with its taint
    assign in_pair.multiplier     = multiplier;
    assign in_pair.multiplier_t   = multiplier_t;
    assign in_pair.multiplicand   = multiplicand;
    assign in_pair.multiplicand_t = multiplicand_t;

    operand_queue operand_queue_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (in_valid),
        .push_data     (in_pair),
        .pop           (pop),
        .head          (head),
        .nonempty      (nonempty),
        .credit_return (credit_return)
    );

    mul_controller mul_controller_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .nonempty     (nonempty),
        .pop          (pop),
        .result_valid (result_valid),
        .step         (step_if.ctrl)
    );

    mul_datapath mul_datapath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .step      (step_if.dp),
        .product   (product),
        .product_t (product_t)
    );

endmodule

//--- sources.f
hdl/taint_mul_pkg.sv
hdl/mul_step_if.sv
hdl/operand_queue.sv
hdl/mul_controller.sv
hdl/mul_datapath.sv
hdl/taint_mul_top.sv
verif/taint_mul_tb.sv

//--- verif/taint_mul_tb.sv
// ======================================
// Testbench for the taint multiplier
// Random credit-based traffic, model check
// ======================================
module taint_mul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W              = taint_mul_pkg::OP_WIDTH;
    localparam int PW             = taint_mul_pkg::PROD_WIDTH;
    localparam int DEPTH          = taint_mul_pkg::OPQ_DEPTH;
    localparam int NUM_OPS        = 300;
    localparam int LATENCY        = 2 * W + 1;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (2 * W + 4);
    localparam int SEED           = 69551;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    logic [W-1:0]  multiplier;
    logic [W-1:0]  multiplier_t;
    logic [W-1:0]  multiplicand;
    logic [W-1:0]  multiplicand_t;
    logic          credit_return;
    logic          result_valid;
    logic [PW-1:0] product;
    logic [PW-1:0] product_t;

    int            cycle;
    int            credits;
    int            results_seen;
    // Pairs in flight as {mr, mr_t, md, md_t}
    logic [4*W-1:0] pending_q[$];
    int             pop_cycle_q[$];

    taint_mul_top taint_mul_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .multiplier     (multiplier),
        .multiplier_t   (multiplier_t),
        .multiplicand   (multiplicand),
        .multiplicand_t (multiplicand_t),
        .credit_return  (credit_return),
        .result_valid   (result_valid),
        .product        (product),
        .product_t      (product_t)
    );

    always #10 clk = ~clk;

    // ======================================
    // Cycle count and timeout
    // ======================================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results seen",
                     cycle, results_seen, NUM_OPS);
            $display("Finished with errors");
            $fatal(1, "simulation did not complete in time");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED time=%0t signal=%s got=0x%0h expected=0x%0h",
                     $time, name, got, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Replay of the taint rules, one multiplier bit per round
    function automatic logic [PW-1:0] model_taint(input logic [W-1:0] mr,
                                                  input logic [W-1:0] mr_t,
                                                  input logic [W-1:0] md,
                                                  input logic [W-1:0] md_t);
        logic [PW:0] s;
        logic [PW:0] st;
        logic [PW:0] a;
        logic [PW:0] at;
        logic [PW:0] ns;
        logic [PW:0] nst;
        logic        c;
        logic        ct;
        logic        cout;
        s  = '0;
        st = '0;
        a  = {1'b0, md, {W{1'b0}}};
        at = {1'b0, md_t, {W{1'b0}}};
        for (int i = 0; i < W; i++) begin
            if (mr[i]) begin
                c  = 1'b0;
                ct = 1'b0;
                for (int k = 0; k <= PW; k++) begin
                    ns[k]  = s[k] ^ a[k] ^ c;
                    nst[k] = st[k] | at[k] | ct;
                    cout   = (s[k] & a[k]) | (s[k] & c) | (a[k] & c);
                    ct     = cout & (st[k] | at[k]);
                    c      = cout;
                end
                s  = ns;
                st = nst;
            end
            // Tainted add/skip choice
            if (mr_t[i]) begin
                st = '1;
            end
            s  = s >> 1;
            st = st >> 1;
        end
        return st[PW-1:0];
    endfunction

    task automatic check_result();
        logic [4*W-1:0] pair;
        logic [W-1:0]   mr;
        logic [W-1:0]   mr_t;
        logic [W-1:0]   md;
        logic [W-1:0]   md_t;
        logic [PW-1:0]  must_set;
        int             issued;
        int             first_t;
        if (pending_q.size() == 0 || pop_cycle_q.size() == 0) begin
            $display("A result arrived with no operand pair outstanding");
            $display("Finished with errors");
            $fatal(1, "unexpected result_valid");
        end else begin
            pair   = pending_q.pop_front();
            issued = pop_cycle_q.pop_front();
            {mr, mr_t, md, md_t} = pair;
            check_value("result_latency", 32'(cycle - issued), 32'(LATENCY));
            check_value("product", 32'(product), 32'({{W{1'b0}}, mr} * {{W{1'b0}}, md}));
            check_value("product_t", 32'(product_t), 32'(model_taint(mr, mr_t, md, md_t)));
            if (mr_t == '0 && md_t == '0) begin
                check_value("product_t_clean", 32'(product_t), 32'd0);
            end
            if (mr_t != '0) begin
                // Everything below the first tainted decision, after its shifts
                first_t = 0;
                for (int k = W - 1; k >= 0; k--) begin
                    if (mr_t[k]) begin
                        first_t = k;
                    end
                end
                must_set = PW'((32'd1 << (W + first_t + 1)) - 1);
                check_value("product_t_after_taint", 32'(product_t & must_set),
                            32'(must_set));
            end
            results_seen++;
        end
    endtask

    // Outputs are sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (credit_return) begin
                pop_cycle_q.push_back(cycle);
            end
            if (result_valid) begin
                check_result();
            end
        end
    end

    // A credit seen this cycle is usable from the next one
    task automatic advance();
        if (credit_return) begin
            credits++;
        end
        check_value("credits_in_range", 32'(credits >= 0 && credits <= DEPTH), 32'd1);
        @(negedge clk);
    endtask

    // ======================================
    // Stimulus
    // ======================================
    initial begin
        int gap;
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        multiplier     = '0;
        multiplier_t   = '0;
        multiplicand   = '0;
        multiplicand_t = '0;
        cycle          = 0;
        credits        = DEPTH;
        results_seen   = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_OPS; i++) begin
            // Mostly back to back, sometimes a short pause
            gap = ($urandom_range(3, 0) == 0) ? $urandom_range(4, 1) : 0;
            in_valid = 1'b0;
            repeat (gap) advance();
            while (credits == 0) begin
                advance();
            end
            multiplier   = W'($urandom);
            multiplicand = W'($urandom);
            if (i < 60) begin
                multiplier_t   = '0;
                multiplicand_t = '0;
            end else if (i < 120) begin
                // Single tainted multiplier bit
                multiplier_t   = W'(1 << $urandom_range(W - 1, 0));
                multiplicand_t = '0;
            end else begin
                multiplier_t   = W'($urandom & $urandom & $urandom);
                multiplicand_t = W'($urandom & $urandom);
            end
            in_valid = 1'b1;
            credits--;
            pending_q.push_back({multiplier, multiplier_t, multiplicand, multiplicand_t});
            advance();
        end
        in_valid = 1'b0;

        // Drain and collect every credit
        while (!(results_seen == NUM_OPS && credits == DEPTH)) begin
            advance();
        end
        // Quiet stretch where no stray result or credit may show up
        repeat (LATENCY + 2) begin
            advance();
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule
